//--- rename.f
+incdir+tb
hdl/rename_pkg.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rename_dispatch.sv
hdl/rename_unit.sv
tb/tb_rename_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f rename.f --top-module tb_rename_unit \
	-Mdir obj_dir -o sim_rename
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_rename > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	echo "run passed"
	exit 0
fi
echo "run failed, see $LOG"
exit 1

//--- tb/rename_model.svh
// rename reference model
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

	int					map_m [rename_pkg::NUM_AREG];	// areg to expected tag
	int					free_q [$];						// free tags, head first
	int					credits_m;						// issue credits left
	logic	[4*PW:0]	exp_q [$];						// {dest_vld, src_a, src_b, dest, old}

	// state right after reset
	task automatic reset_model();
		free_q.delete();
		exp_q.delete();
		for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
			map_m[i] = i;		// identity
		end
		for (int t = rename_pkg::NUM_AREG; t < NUM_PREG; t++) begin
			free_q.push_back(t);	// ascending
		end
		credits_m = ISSUE_CREDITS;
	endtask

	// ready as seen before the edge
	function automatic bit predict_ready(input rename_pkg::areg_idx_t dest);
		return (credits_m != 0) && (free_q.size() != 0 || dest == rename_pkg::ZERO_REG);
	endfunction

	// renamed result of one accepted instruction
	task automatic predict_accept(
		input rename_pkg::areg_idx_t	src_a,
		input rename_pkg::areg_idx_t	src_b,
		input rename_pkg::areg_idx_t	dest
	);
		logic				dest_vld;
		int					new_tag;
		logic	[4*PW:0]	rec;
		dest_vld = (dest != rename_pkg::ZERO_REG);
		new_tag  = 0;
		if (dest_vld && free_q.size() != 0) begin
			new_tag = free_q.pop_front();
		end
		// sources and old tag come from the map before this write
		rec = {dest_vld, PW'(map_m[src_a]), PW'(map_m[src_b]), PW'(new_tag), PW'(map_m[dest])};
		if (dest_vld) begin
			map_m[dest] = new_tag;
		end
		exp_q.push_back(rec);
		credits_m--;
	endtask

	// retired tag goes to the back of the free list
	task automatic predict_retire(input logic [PW-1:0] tag);
		free_q.push_back(int'(tag));
	endtask

`endif

//--- tb/tb_rename_unit.sv
// rename unit testbench
`timescale 1ns/100ps

module tb_rename_unit;

	localparam int NUM_PREG      = rename_pkg::DEF_NUM_PREG;
	localparam int ISSUE_CREDITS = rename_pkg::DEF_ISSUE_CREDITS;
	localparam int PW            = $clog2(NUM_PREG);
	localparam int NUM_INST      = 400;		// accepts per run
	localparam int CLK_PERIOD    = 10;

	logic						clk = 1'b0;
	logic						rst_n_i = 1'b0;
	logic						inst_vld_i = 1'b0;
	rename_pkg::areg_idx_t		src_a_areg_i = '0;
	rename_pkg::areg_idx_t		src_b_areg_i = '0;
	rename_pkg::areg_idx_t		dest_areg_i = '0;
	logic						inst_rdy_o;
	logic						out_vld_o;
	logic	[PW-1:0]			out_src_a_preg_o;
	logic	[PW-1:0]			out_src_b_preg_o;
	logic	[PW-1:0]			out_dest_preg_o;
	logic	[PW-1:0]			out_old_preg_o;
	logic						out_dest_vld_o;
	logic						credit_return_i = 1'b0;
	logic						retire_vld_i = 1'b0;
	logic	[PW-1:0]			retire_preg_i = '0;

	// next input values, picked at the falling edge
	logic						nxt_vld = 1'b0;
	rename_pkg::areg_idx_t		nxt_src_a = '0;
	rename_pkg::areg_idx_t		nxt_src_b = '0;
	rename_pkg::areg_idx_t		nxt_dest = '0;
	logic						nxt_credit = 1'b0;
	logic						nxt_retire = 1'b0;
	logic	[PW-1:0]			nxt_retire_preg = '0;

	integer						seed = 32'hd58f9ef2;
	int							chk_err_cnt = 0;	// monitor side
	int							seq_err_cnt = 0;	// sequence side
	int							accept_cnt = 0;
	int							out_cnt = 0;
	int							iq_occ = 0;			// issue queue entries held
	logic						stim_en = 1'b0;
	logic						cred_en = 1'b0;
	logic						ret_en = 1'b0;
	logic						starve_seen = 1'b0;	// free list ran dry under load
	logic						out_vld_exp = 1'b0;	// accept of the previous edge
	logic	[PW-1:0]			rob_q [$];			// old tags in retire order

	`include "rename_model.svh"

	rename_unit #(
		.NUM_PREG		(NUM_PREG),
		.ISSUE_CREDITS	(ISSUE_CREDITS)
	) u_rename_unit (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			chk_err_cnt++;
		end
	endtask

	task automatic check_output(input logic [4*PW:0] rec);
		check_field("out_dest_vld_o", 32'(out_dest_vld_o), 32'(rec[4*PW]));
		check_field("out_src_a_preg_o", 32'(out_src_a_preg_o), 32'(rec[4*PW-1 -: PW]));
		check_field("out_src_b_preg_o", 32'(out_src_b_preg_o), 32'(rec[3*PW-1 -: PW]));
		if (rec[4*PW]) begin		// dest fields only mean something here
			check_field("out_dest_preg_o", 32'(out_dest_preg_o), 32'(rec[2*PW-1 -: PW]));
			check_field("out_old_preg_o", 32'(out_old_preg_o), 32'(rec[PW-1:0]));
		end
	endtask

	//==========================================================================
	// monitor, model and stimulus choice, mid cycle
	//==========================================================================
	always @(negedge clk) begin : monitor_blk
		logic	[4*PW:0]	rec;
		logic				accept;
		if (!rst_n_i) begin
			reset_model();
			out_vld_exp = 1'b0;
		end else begin
			// one pulse exactly one cycle after each accept edge
			check_field("out_vld_o", 32'(out_vld_o), 32'(out_vld_exp));
			if (out_vld_o) begin	// issue queue takes every output
				out_cnt++;
				iq_occ++;
				assert (exp_q.size() != 0) else begin
					$display("ERROR: out_vld_o pulse with no accepted instruction at %0t", $time);
					chk_err_cnt++;
				end
				if (exp_q.size() != 0) begin
					rec = exp_q.pop_front();
					check_output(rec);
					if (rec[4*PW]) rob_q.push_back(rec[PW-1:0]);
				end
			end
			if (credit_return_i) iq_occ--;
			assert (iq_occ <= ISSUE_CREDITS) else begin
				$display("ERROR: issue queue overfilled with %0d entries at %0t", iq_occ, $time);
				chk_err_cnt++;
			end
			// handshake of the coming edge
			check_field("inst_rdy_o", 32'(inst_rdy_o), 32'(predict_ready(dest_areg_i)));
			accept = inst_vld_i && inst_rdy_o;
			if (inst_vld_i && !inst_rdy_o && free_q.size() == 0 &&
					dest_areg_i != rename_pkg::ZERO_REG) starve_seen = 1'b1;
			if (accept) begin
				predict_accept(src_a_areg_i, src_b_areg_i, dest_areg_i);
				accept_cnt++;
			end
			out_vld_exp = accept;
			if (credit_return_i) credits_m++;		// after the ready check
			if (retire_vld_i) predict_retire(retire_preg_i);
			// unaccepted instruction is held
			if (accept || !inst_vld_i) begin
				nxt_vld   = stim_en && (($random(seed) & 3) != 0);
				nxt_src_a = rename_pkg::areg_idx_t'($random(seed));
				nxt_src_b = rename_pkg::areg_idx_t'($random(seed));
				nxt_dest  = (($random(seed) & 7) == 0) ? rename_pkg::ZERO_REG :
					rename_pkg::areg_idx_t'($random(seed));
			end
			nxt_credit = cred_en && iq_occ > 0 && (($random(seed) & 1) != 0);
			nxt_retire = ret_en && rob_q.size() != 0 && (($random(seed) & 1) != 0);
			if (nxt_retire) nxt_retire_preg = rob_q.pop_front();	// in order ROB
		end
	end

	always @(posedge clk) begin
		inst_vld_i      <= nxt_vld;
		src_a_areg_i    <= nxt_src_a;
		src_b_areg_i    <= nxt_src_b;
		dest_areg_i     <= nxt_dest;
		credit_return_i <= nxt_credit;
		retire_vld_i    <= nxt_retire;
		retire_preg_i   <= nxt_retire_preg;
	end

	//==========================================================================
	// test sequence
	//==========================================================================
	initial begin
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		stim_en <= 1'b1;
		// no returns, so credits alone stop the flow
		while (accept_cnt < ISSUE_CREDITS) @(posedge clk);
		repeat (2 * ISSUE_CREDITS) @(posedge clk);
		assert (accept_cnt == ISSUE_CREDITS) else begin
			$display("ERROR: %0d instructions accepted with no credit return, expected %0d",
				accept_cnt, ISSUE_CREDITS);
			seq_err_cnt++;
		end
		cred_en <= 1'b1;		// nothing retires yet, free list drains
		while (!starve_seen) @(posedge clk);
		ret_en <= 1'b1;
		while (accept_cnt < NUM_INST) @(posedge clk);
		stim_en <= 1'b0;
		while (inst_vld_i || exp_q.size() != 0) @(posedge clk);
		$display("Run end: %0d accepted, %0d renamed out, %0d errors (%0d check, %0d sequence)",
			accept_cnt, out_cnt, chk_err_cnt + seq_err_cnt, chk_err_cnt, seq_err_cnt);
		if (chk_err_cnt + seq_err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(20 * NUM_INST * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d clock periods with %0d accepted, %0d errors",
			20 * NUM_INST, accept_cnt, chk_err_cnt + seq_err_cnt);
		$display("Simulation failed");
		$finish;
	end

endmodule: tb_rename_unit

//--- hdl/rename_unit.sv
// register rename unit top level
`timescale 1ns/100ps

module rename_unit #(
	parameter int NUM_PREG      = rename_pkg::DEF_NUM_PREG,
	parameter int ISSUE_CREDITS = rename_pkg::DEF_ISSUE_CREDITS
) (
	input									clk,
	input									rst_n_i,

	// decoded instruction in
	input									inst_vld_i,
	input	rename_pkg::areg_idx_t			src_a_areg_i,
	input	rename_pkg::areg_idx_t			src_b_areg_i,
	input	rename_pkg::areg_idx_t			dest_areg_i,
	output	logic							inst_rdy_o,

	// renamed instruction out, credit based
	output	logic							out_vld_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_src_a_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_src_b_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_dest_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_old_preg_o,
	output	logic							out_dest_vld_o,
	input									credit_return_i,

	// retire port from the ROB
	input									retire_vld_i,
	input			[$clog2(NUM_PREG)-1:0]	retire_preg_i
);

	localparam int PREG_IDX_W = $clog2(NUM_PREG);

	logic						alloc_en;		// pop plus map write
	logic						fl_empty;
	logic	[PREG_IDX_W-1:0]	fl_head_preg;	// tnew
	logic	[PREG_IDX_W-1:0]	mt_src_a_preg;
	logic	[PREG_IDX_W-1:0]	mt_src_b_preg;
	logic	[PREG_IDX_W-1:0]	mt_old_preg;	// told

	//==========================================================================
	// map table and free list, side by side
	//==========================================================================
	map_table #(
		.NUM_PREG		(NUM_PREG)
	) u_map_table (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.src_a_areg_i	(src_a_areg_i),
		.src_b_areg_i	(src_b_areg_i),
		.dest_areg_i	(dest_areg_i),
		.wr_en_i		(alloc_en),
		.new_preg_i		(fl_head_preg),
		.src_a_preg_o	(mt_src_a_preg),
		.src_b_preg_o	(mt_src_b_preg),
		.old_preg_o		(mt_old_preg)
	);

	free_list #(
		.NUM_PREG		(NUM_PREG)
	) u_free_list (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.pop_en_i		(alloc_en),
		.push_en_i		(retire_vld_i),		// straight from retire
		.push_preg_i	(retire_preg_i),
		.head_preg_o	(fl_head_preg),
		.empty_o		(fl_empty)
	);

	//==========================================================================
	// dispatch
	//==========================================================================
	rename_dispatch #(
		.NUM_PREG			(NUM_PREG),
		.ISSUE_CREDITS		(ISSUE_CREDITS)
	) u_rename_dispatch (
		.clk				(clk),
		.rst_n_i			(rst_n_i),
		.inst_vld_i			(inst_vld_i),
		.dest_areg_i		(dest_areg_i),
		.inst_rdy_o			(inst_rdy_o),
		.fl_empty_i			(fl_empty),
		.head_preg_i		(fl_head_preg),
		.src_a_preg_i		(mt_src_a_preg),
		.src_b_preg_i		(mt_src_b_preg),
		.old_preg_i			(mt_old_preg),
		.alloc_en_o			(alloc_en),
		.credit_return_i	(credit_return_i),
		.out_vld_o			(out_vld_o),
		.out_src_a_preg_o	(out_src_a_preg_o),
		.out_src_b_preg_o	(out_src_b_preg_o),
		.out_dest_preg_o	(out_dest_preg_o),
		.out_old_preg_o		(out_old_preg_o),
		.out_dest_vld_o		(out_dest_vld_o)
	);

endmodule: rename_unit

//--- hdl/rename_dispatch.sv
// rename dispatch and issue credit control
`timescale 1ns/100ps

module rename_dispatch #(
	parameter int NUM_PREG      = rename_pkg::DEF_NUM_PREG,
	parameter int ISSUE_CREDITS = rename_pkg::DEF_ISSUE_CREDITS
) (
	input									clk,
	input									rst_n_i,

	// decoder handshake
	input									inst_vld_i,
	input	rename_pkg::areg_idx_t			dest_areg_i,
	output	logic							inst_rdy_o,

	// free list and map table results
	input									fl_empty_i,
	input			[$clog2(NUM_PREG)-1:0]	head_preg_i,
	input			[$clog2(NUM_PREG)-1:0]	src_a_preg_i,
	input			[$clog2(NUM_PREG)-1:0]	src_b_preg_i,
	input			[$clog2(NUM_PREG)-1:0]	old_preg_i,
	output	logic							alloc_en_o,		// pop and map write

	// toward the issue queue
	input									credit_return_i,
	output	logic							out_vld_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_src_a_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_src_b_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_dest_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	out_old_preg_o,
	output	logic							out_dest_vld_o
);

	localparam int CRED_W = $clog2(ISSUE_CREDITS + 1);

	logic	[CRED_W-1:0]	credit_r;		// free issue queue slots
	logic					dest_vld;
	logic					accept;

	//==========================================================================
	// accept decision
	//==========================================================================
	assign dest_vld   = (dest_areg_i != rename_pkg::ZERO_REG);	// zero reg takes no tag
	assign inst_rdy_o = (credit_r != '0) && (!fl_empty_i || !dest_vld);
	assign accept     = inst_vld_i && inst_rdy_o;
	assign alloc_en_o = accept && dest_vld;

	// credit leaves at accept, the matching out_vld_o follows one cycle later
	// so the in-flight instruction is already counted against the queue
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_r <= CRED_W'(ISSUE_CREDITS);
		end else if (accept && !credit_return_i) begin
			credit_r <= credit_r - CRED_W'(1);
		end else if (!accept && credit_return_i) begin
			credit_r <= credit_r + CRED_W'(1);		// slot freed in the issue queue
		end
	end

	//==========================================================================
	// renamed instruction register
	//==========================================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_vld_o <= 1'b0;
		end else begin
			out_vld_o <= accept;			// one pulse per accepted inst
		end
	end

	// payload only loads on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			out_src_a_preg_o <= src_a_preg_i;
			out_src_b_preg_o <= src_b_preg_i;
			out_dest_preg_o  <= head_preg_i;	// don't care without dest_vld
			out_old_preg_o   <= old_preg_i;
			out_dest_vld_o   <= dest_vld;
		end
	end

endmodule: rename_dispatch

//--- hdl/free_list.sv
// circular free list of physical tags
`timescale 1ns/100ps

module free_list #(
	parameter int NUM_PREG = rename_pkg::DEF_NUM_PREG
) (
	input									clk,
	input									rst_n_i,

	input									pop_en_i,		// allocation at dispatch
	input									push_en_i,		// release at retire
	input			[$clog2(NUM_PREG)-1:0]	push_preg_i,	// old tag from the ROB

	output	logic	[$clog2(NUM_PREG)-1:0]	head_preg_o,	// next tag to hand out
	output	logic							empty_o
);

	localparam int PREG_IDX_W = $clog2(NUM_PREG);
	localparam int PTR_W      = $clog2(NUM_PREG);
	localparam int CNT_W      = $clog2(NUM_PREG + 1);
	localparam int NUM_FREE   = NUM_PREG - rename_pkg::NUM_AREG;	// tags free after reset

	logic	[PREG_IDX_W-1:0]	fifo_r [NUM_PREG];
	logic	[PTR_W-1:0]			head_r;
	logic	[PTR_W-1:0]			tail_r;
	logic	[CNT_W-1:0]			count_r;

	logic						pop;
	logic						push;

	assign pop  = pop_en_i && !empty_o;		// never pop past the last tag
	assign push = push_en_i;

	//==========================================================================
	// queue storage and pointers
	//==========================================================================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// preload NUM_AREG .. NUM_PREG-1 in ascending order
			for (int i = 0; i < NUM_PREG; i++) begin
				fifo_r[i] <= (i < NUM_FREE) ? PREG_IDX_W'(i + rename_pkg::NUM_AREG) : '0;
			end
			head_r  <= '0;
			tail_r  <= PTR_W'(NUM_FREE);
			count_r <= CNT_W'(NUM_FREE);
		end else begin
			if (push) begin
				fifo_r[tail_r] <= push_preg_i;		// readable from next cycle
				tail_r <= (tail_r == PTR_W'(NUM_PREG - 1)) ? '0 : tail_r + PTR_W'(1);
			end
			if (pop) begin
				head_r <= (head_r == PTR_W'(NUM_PREG - 1)) ? '0 : head_r + PTR_W'(1);
			end
			// occupancy, push and pop together leave it unchanged
			case ({push, pop})
				2'b10:   count_r <= count_r + CNT_W'(1);
				2'b01:   count_r <= count_r - CNT_W'(1);
				default: count_r <= count_r;
			endcase
		end
	end

	//==========================================================================
	// outputs
	//==========================================================================
	assign head_preg_o = fifo_r[head_r];
	assign empty_o     = (count_r == '0);	// from registered count only

endmodule: free_list

//--- hdl/map_table.sv
// architectural to physical map table
`timescale 1ns/100ps

module map_table #(
	parameter int NUM_PREG = rename_pkg::DEF_NUM_PREG
) (
	input									clk,
	input									rst_n_i,

	// lookups from the decoded instruction
	input	rename_pkg::areg_idx_t			src_a_areg_i,
	input	rename_pkg::areg_idx_t			src_b_areg_i,
	input	rename_pkg::areg_idx_t			dest_areg_i,

	// remap of the destination on allocation
	input									wr_en_i,
	input			[$clog2(NUM_PREG)-1:0]	new_preg_i,		// tag popped from free list

	output	logic	[$clog2(NUM_PREG)-1:0]	src_a_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	src_b_preg_o,
	output	logic	[$clog2(NUM_PREG)-1:0]	old_preg_o		// goes to the ROB as told
);

	localparam int PREG_IDX_W = $clog2(NUM_PREG);

	// one physical tag per architectural register
	logic	[PREG_IDX_W-1:0]	map_r [rename_pkg::NUM_AREG];

	//==========================================================================
	// mapping storage
	//==========================================================================
	// reset maps areg i to preg i, so the first NUM_AREG tags are all in use
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
				map_r[i] <= PREG_IDX_W'(i);		// identity
			end
		end else if (wr_en_i) begin
			map_r[dest_areg_i] <= new_preg_i;	// seen by the next instruction
		end
	end

	//==========================================================================
	// combinational reads
	//==========================================================================
	// all three reads see the table before this cycle's write
	// so a source naming its own dest gets the previous producer
	assign src_a_preg_o	= map_r[src_a_areg_i];
	assign src_b_preg_o	= map_r[src_b_areg_i];
	assign old_preg_o	= map_r[dest_areg_i];		// freed when this inst retires

endmodule: map_table

//--- hdl/rename_pkg.sv
// rename front end shared constants

package rename_pkg;

	//==========================================================================
	// architectural register file, fixed by the ISA
	//==========================================================================
	localparam int NUM_AREG   = 32;		// architectural registers
	localparam int AREG_IDX_W = 5;		// bits per architectural index

	typedef logic [AREG_IDX_W-1:0] areg_idx_t;

	// hard-wired zero register, never renamed
	localparam areg_idx_t ZERO_REG = 5'd31;

	//==========================================================================
	// defaults for the top level parameters
	//==========================================================================
	localparam int DEF_NUM_PREG      = 64;	// physical register file size
	localparam int DEF_ISSUE_CREDITS = 8;	// issue queue capacity

endpackage: rename_pkg
